// ==== Bender.yml ====
package:
  name: io_subsystem

sources:
  - files:
      - logic/eio_pkg.sv
      - logic/external_register.sv
      - logic/io_bus_decoder.sv
      - logic/io_interval_timer.sv
      - logic/io_gpio_port.sv
      - logic/io_subsystem.sv

  - target: simulation
    files:
      - dv/io_subsystem_tb.sv

// ==== dv/io_subsystem_tb.sv ====
/*
 * Trace-driven testbench for the external I/O subsystem
 * Clock and reset, bus driver, pin driver and response checks
 */

`timescale 1ns/1ps

module io_subsystem_tb;

	localparam int          ACK_TIMEOUT = 20;             // Cycles to wait for ack
	localparam int          IRQ_TIMEOUT = 2000;           // Cycles to wait for irq level
	localparam int          DRIVE_DLY   = 1;              // Input skew after rising edge
	localparam logic [15:0] REG_BASE    = 16'h0100;
	localparam logic [15:0] GPIO_BASE   = 16'h0300;

	logic              clk_in = 1'b0;
	logic              reset_in;
	eio_pkg::eio_req_t bus_req;
	eio_pkg::eio_ack_t bus_ack;
	logic [7:0]        gpio_in;
	logic [7:0]        gpio_out;
	logic              irq_out;

	int                errors = 0;
	int                checks = 0;
	integer            seed;                              // $random state
	logic [31:0]       reg_model;                         // Expected scratch register

	io_subsystem DUT (
		.clk_in   (clk_in),
		.reset_in (reset_in),
		.bus_req  (bus_req),
		.bus_ack  (bus_ack),
		.gpio_in  (gpio_in),
		.gpio_out (gpio_out),
		.irq_out  (irq_out)
	);

	always #5 clk_in = ~clk_in;                           // 10 ns period

	// One transfer with drive, ack wait, timing check and release
	task automatic bus_transfer(input logic [15:0] addr, input eio_pkg::eio_op_e op,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic fault);
		int   cycles;
		logic got_ack;
		begin
			cycles  = 0;
			got_ack = 1'b0;
			rdata   = '0;
			fault   = 1'b0;
			@(posedge clk_in);
			#DRIVE_DLY;
			bus_req.req     = 1'b1;
			bus_req.addr    = addr;
			bus_req.op      = op;
			bus_req.wr_data = wdata;
			while (!got_ack && cycles < ACK_TIMEOUT)
			begin
				@(negedge clk_in);                        // Outputs settled mid-cycle
				cycles++;
				if (bus_ack.ack)
				begin
					got_ack = 1'b1;
					rdata   = bus_ack.ack_data;
					fault   = bus_ack.ack_fault;
				end
			end
			checks++;
			if (!got_ack)
			begin
				$display("timeout: no acknowledge for address %h within %0d cycles",
					addr, ACK_TIMEOUT);
				errors++;
			end
			else
				assert (cycles == 2)                      // Ack in 2nd cycle of request
				else
				begin
					$display("mismatch at %0t: ack after %0d cycles, address %h",
						$time, cycles, addr);
					errors++;
				end
			@(posedge clk_in);                            // Edge that ends the ack cycle
			#DRIVE_DLY;
			bus_req = '0;
			checks++;
			assert (!bus_ack.ack)
			else
			begin
				$display("mismatch at %0t: ack still high after transfer, address %h",
					$time, addr);
				errors++;
			end
		end
	endtask

	task automatic write_word(input logic [15:0] addr, input logic [31:0] data,
		input logic exp_fault);
		logic [31:0] rdata;
		logic        fault;
		begin
			bus_transfer(addr, eio_pkg::EIO_WRITE, data, rdata, fault);
			checks++;
			assert (fault == exp_fault)
			else
			begin
				$display("mismatch at %0t: write %h fault %b, expected %b",
					$time, addr, fault, exp_fault);
				errors++;
			end
			if (addr == REG_BASE)
				reg_model = data;
			if (addr == GPIO_BASE)
			begin
				checks++;
				assert (gpio_out == data[7:0])            // Pins follow OUT at once
				else
				begin
					$display("mismatch at %0t: gpio_out %h, expected %h",
						$time, gpio_out, data[7:0]);
					errors++;
				end
			end
		end
	endtask

	task automatic read_word(input logic [15:0] addr, input logic [31:0] exp_data,
		input logic exp_fault);
		logic [31:0] rdata;
		logic        fault;
		begin
			bus_transfer(addr, eio_pkg::EIO_READ, '0, rdata, fault);
			checks++;
			assert (fault == exp_fault && rdata == exp_data)
			else
			begin
				$display("mismatch at %0t: read %h got %h fault %b, expected %h fault %b",
					$time, addr, rdata, fault, exp_data, exp_fault);
				errors++;
			end
		end
	endtask

	// New pin value held long enough to pass the synchronizer
	task automatic drive_pins(input logic [7:0] value);
		begin
			@(posedge clk_in);
			#DRIVE_DLY;
			gpio_in = value;
			repeat (3) @(posedge clk_in);
		end
	endtask

	task automatic wait_irq(input logic level);
		int cycles;
		begin
			cycles = 0;
			while (irq_out !== level && cycles < IRQ_TIMEOUT)
			begin
				@(negedge clk_in);
				cycles++;
			end
			if (irq_out !== level)
			begin
				$display("timeout: irq_out did not reach %b within %0d cycles",
					level, IRQ_TIMEOUT);
				errors++;
			end
		end
	endtask

	initial
	begin
		integer      fd;
		integer      code;
		logic [63:0] act_tok;                             // Action letter right aligned
		logic [1023:0] line_buf;
		logic [31:0] f_addr;
		logic [31:0] f_data;
		logic [31:0] f_exp;
		logic [31:0] f_flt;
		logic [31:0] rnd;
		seed      = 57396;
		reset_in  = 1'b1;
		bus_req   = '0;
		gpio_in   = '0;
		reg_model = '0;
		repeat (4) @(posedge clk_in);
		#DRIVE_DLY;
		reset_in = 1'b0;
		fd = $fopen("dv/io_subsystem_trace.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the trace file dv/io_subsystem_trace.txt");
			errors++;
		end
		else
		begin
			while (!$feof(fd))
			begin
				act_tok = '0;
				code = $fscanf(fd, "%s", act_tok);
				if (code != 1)
					break;                                // Trailing blank lines
				if (act_tok == "#")
					code = $fgets(line_buf, fd);          // Comment line
				else
				begin
					code = $fscanf(fd, "%h %h %h %h", f_addr, f_data, f_exp, f_flt);
					case (act_tok)
						"W": write_word(f_addr[15:0], f_data, f_flt[0]);
						"R": read_word(f_addr[15:0], f_exp, f_flt[0]);
						"N":
						begin
							rnd = $random(seed);
							write_word(f_addr[15:0], rnd, f_flt[0]);
						end
						"M": read_word(f_addr[15:0], reg_model, f_flt[0]);
						"P": drive_pins(f_addr[7:0]);
						"T": wait_irq(f_exp[0]);
						default:
						begin
							$display("unknown action in trace file, ignored");
							errors++;
						end
					endcase
				end
			end
			$fclose(fd);
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

// ==== dv/io_subsystem_trace.txt ====
# act addr data expect fault, hex. W write, R read, N random write, M read vs model
# P drive gpio_in with addr column for 3 cycles, T wait for irq_out equal to expect
R 0100 0 00000000 0
W 0100 a5a55a5a 0 0
R 0100 0 a5a55a5a 0
W 0104 12345678 0 1
R 0104 0 00000000 1
R 0100 0 a5a55a5a 0
R 0000 0 00000000 1
W 0204 87654321 0 1
R 0100 0 a5a55a5a 0
N 0100 0 0 0
M 0100 0 0 0
W 0300 0000003c 0 0
R 0300 0 0000003c 0
P 96 0 0 0
R 0301 0 00000096 0
W 0301 000000ff 0 0
R 0300 0 0000003c 0
W 0202 00000005 0 0
W 0200 00000001 0 0
T 0 0 1 0
R 0203 0 00000001 0
W 0203 00000001 0 0
T 0 0 0 0
R 0203 0 00000000 0

// ==== io_subsystem.f ====
logic/eio_pkg.sv
logic/external_register.sv
logic/io_bus_decoder.sv
logic/io_interval_timer.sv
logic/io_gpio_port.sv
logic/io_subsystem.sv
dv/io_subsystem_tb.sv

// ==== logic/eio_pkg.sv ====
/*
 * External I/O bus widths, transfer opcode,
 * and the request and acknowledge structs
 */

package eio_pkg;

	// Bus geometry
	localparam int EIO_ADDR_W = 16;                   // I/O word address
	localparam int EIO_DATA_W = 32;                   // Data word

	// Register, timer and GPIO behind the decoder
	localparam int EIO_SLAVE_COUNT = 3;

	// Transfer direction
	typedef enum logic [0:0]
	{
		EIO_READ  = 1'b0,                             // Slave returns ack_data
		EIO_WRITE = 1'b1                              // Slave takes wr_data
	} eio_op_e;

	// Master to slave
	// The master holds every field steady until it samples ack
	typedef struct packed
	{
		logic                  req;                   // Transfer request level
		logic [EIO_ADDR_W-1:0] addr;                  // Word address
		eio_op_e               op;                    // Read or write
		logic [EIO_DATA_W-1:0] wr_data;               // Used on writes only
	} eio_req_t;

	// Slave to master
	typedef struct packed
	{
		logic                  ack;                   // One-cycle pulse
		logic                  ack_fault;             // Valid with ack
		logic [EIO_DATA_W-1:0] ack_data;              // Valid with ack on reads
	} eio_ack_t;

endpackage

// ==== logic/external_register.sv ====
/*
 * 32-bit read/write scratch register on the external I/O bus
 */

`timescale 1ns/1ps

module external_register (
	input  logic              clk_in,                 // Clock
	input  logic              reset_in,               // Sync reset, active high
	input  eio_pkg::eio_req_t req,                    // Request from decoder
	output eio_pkg::eio_ack_t ack                     // Acknowledge to decoder
);

	typedef enum logic [1:0]
	{
		WAIT_REQ,                                     // Idle until req
		RD_ACK,                                       // Return register
		WR_ACK                                        // Load register
	} ack_state_e;

	ack_state_e                      state;
	ack_state_e                      next_state;
	logic [eio_pkg::EIO_DATA_W-1:0]  register;
	logic                            reg_wr;          // Load strobe in WR_ACK only

	always_ff @(posedge clk_in)
	begin
		if (reset_in)
		begin
			state    <= WAIT_REQ;
			register <= '0;
		end
		else
		begin
			state <= next_state;
			if (reg_wr)
				register <= req.wr_data;              // Write lands at end of ack cycle
		end
	end

	always_comb
	begin
		ack        = '0;                              // ack_fault never set here
		reg_wr     = 1'b0;
		next_state = state;
		case (state)
			WAIT_REQ:
			begin
				if (req.req)
					next_state = (req.op == eio_pkg::EIO_WRITE) ? WR_ACK : RD_ACK;
			end
			RD_ACK:
			begin
				ack.ack      = 1'b1;
				ack.ack_data = register;
				next_state   = WAIT_REQ;
			end
			WR_ACK:
			begin
				ack.ack    = 1'b1;
				reg_wr     = 1'b1;
				next_state = WAIT_REQ;
			end
			default: next_state = WAIT_REQ;          // Recover from illegal encoding
		endcase
	end

endmodule

// ==== logic/io_bus_decoder.sv ====
/*
 * External I/O address decoder: request routing, acknowledge merge,
 * and fault response for unmapped addresses
 */

`timescale 1ns/1ps

module io_bus_decoder #(
	parameter logic [eio_pkg::EIO_ADDR_W-1:0] REG_BASE   = 16'h0100,
	parameter logic [eio_pkg::EIO_ADDR_W-1:0] TIMER_BASE = 16'h0200,
	parameter logic [eio_pkg::EIO_ADDR_W-1:0] GPIO_BASE  = 16'h0300
) (
	input  logic              clk_in,                 // Clock
	input  logic              reset_in,               // Sync reset, active high
	input  eio_pkg::eio_req_t bus_req,                // From master
	output eio_pkg::eio_ack_t bus_ack,                // To master
	output eio_pkg::eio_req_t slave_req [eio_pkg::EIO_SLAVE_COUNT],
	input  eio_pkg::eio_ack_t slave_ack [eio_pkg::EIO_SLAVE_COUNT]
);

	localparam int AW = eio_pkg::EIO_ADDR_W;
	localparam int NS = eio_pkg::EIO_SLAVE_COUNT;

	// Slot 0 register, slot 1 timer, slot 2 GPIO
	localparam logic [AW-1:0] BASE [NS] = '{REG_BASE, TIMER_BASE, GPIO_BASE};
	localparam logic [AW-1:0] SPAN [NS] = '{AW'(1), AW'(4), AW'(2)};   // Window sizes in words

	typedef enum logic
	{
		FLT_IDLE,                                     // No fault pending
		FLT_ACK                                       // Answering an unmapped access
	} flt_state_e;

	flt_state_e       flt_state;
	flt_state_e       flt_next;
	logic [NS-1:0]    sel;                            // One-hot window match
	logic             unmapped;

	// Window match per slave
	always_comb
	begin
		for (int i = 0; i < NS; i++)
			sel[i] = (bus_req.addr >= BASE[i]) && ((bus_req.addr - BASE[i]) < SPAN[i]);
	end

	assign unmapped = bus_req.req && (sel == '0);

	// Request fans out and req goes only to the hit slave
	always_comb
	begin
		for (int i = 0; i < NS; i++)
		begin
			slave_req[i]     = bus_req;
			slave_req[i].req = bus_req.req & sel[i];
		end
	end

	always_ff @(posedge clk_in)
	begin
		if (reset_in)
			flt_state <= FLT_IDLE;
		else
			flt_state <= flt_next;
	end

	always_comb
	begin
		flt_next = FLT_IDLE;
		if (flt_state == FLT_IDLE && unmapped)
			flt_next = FLT_ACK;                       // Fault ack one cycle after req
	end

	// At most one source acks in any cycle
	always_comb
	begin
		bus_ack = '0;
		if (flt_state == FLT_ACK)
		begin
			bus_ack.ack       = 1'b1;
			bus_ack.ack_fault = 1'b1;                 // Data stays zero
		end
		for (int i = 0; i < NS; i++)
		begin
			if (slave_ack[i].ack)
				bus_ack = slave_ack[i];
		end
	end

endmodule

// ==== logic/io_gpio_port.sv ====
/*
 * GPIO slave: output register and two-stage input synchronizer
 */

`timescale 1ns/1ps

module io_gpio_port (
	input  logic              clk_in,                 // Clock
	input  logic              reset_in,               // Sync reset, active high
	input  eio_pkg::eio_req_t req,                    // Request from decoder
	output eio_pkg::eio_ack_t ack,                    // Acknowledge to decoder
	input  logic [7:0]        gpio_in,                // Asynchronous pins
	output logic [7:0]        gpio_out                // Driven pins
);

	localparam int DW = eio_pkg::EIO_DATA_W;

	localparam logic OFS_OUT = 1'b0;                  // Read/write
	localparam logic OFS_IN  = 1'b1;                  // Read only

	typedef enum logic [1:0]
	{
		WAIT_REQ,
		RD_ACK,
		WR_ACK
	} ack_state_e;

	ack_state_e  state;
	ack_state_e  next_state;
	logic [7:0]  out_reg;
	logic [7:0]  in_meta;                             // First sync stage
	logic [7:0]  in_sync;                             // Safe to read
	logic        out_wr;

	assign gpio_out = out_reg;

	always_ff @(posedge clk_in)
	begin
		if (reset_in)
		begin
			state   <= WAIT_REQ;
			out_reg <= '0;
			in_meta <= '0;
			in_sync <= '0;
		end
		else
		begin
			state   <= next_state;
			in_meta <= gpio_in;
			in_sync <= in_meta;
			if (out_wr)
				out_reg <= req.wr_data[7:0];
		end
	end

	always_comb
	begin
		ack        = '0;
		out_wr     = 1'b0;
		next_state = state;
		case (state)
			WAIT_REQ:
			begin
				if (req.req)
					next_state = (req.op == eio_pkg::EIO_WRITE) ? WR_ACK : RD_ACK;
			end
			RD_ACK:
			begin
				ack.ack      = 1'b1;
				ack.ack_data = (req.addr[0] == OFS_IN) ? DW'(in_sync) : DW'(out_reg);
				next_state   = WAIT_REQ;
			end
			WR_ACK:
			begin
				ack.ack    = 1'b1;
				out_wr     = (req.addr[0] == OFS_OUT);   // IN write is acked and dropped
				next_state = WAIT_REQ;
			end
			default: next_state = WAIT_REQ;
		endcase
	end

endmodule

// ==== logic/io_interval_timer.sv ====
/*
 * Interval timer slave: prescaled counter, compare match,
 * sticky expired flag and interrupt level
 */

`timescale 1ns/1ps

module io_interval_timer #(
	parameter int PRESCALE = 4                        // Clocks per count step
) (
	input  logic              clk_in,                 // Clock
	input  logic              reset_in,               // Sync reset, active high
	input  eio_pkg::eio_req_t req,                    // Request from decoder
	output eio_pkg::eio_ack_t ack,                    // Acknowledge to decoder
	output logic              irq_out                 // Interrupt level
);

	localparam int DW   = eio_pkg::EIO_DATA_W;
	localparam int PS_W = $clog2(PRESCALE + 1);
	localparam logic [PS_W-1:0] PS_LAST = PS_W'(PRESCALE - 1);

	// Word offsets from the timer base
	localparam logic [1:0] OFS_CTRL    = 2'd0;        // Bit 0 enable
	localparam logic [1:0] OFS_COUNT   = 2'd1;
	localparam logic [1:0] OFS_COMPARE = 2'd2;
	localparam logic [1:0] OFS_STATUS  = 2'd3;        // Bit 0 expired and write 1 clears

	typedef enum logic [1:0]
	{
		WAIT_REQ,
		RD_ACK,
		WR_ACK
	} ack_state_e;

	ack_state_e       state;
	ack_state_e       next_state;
	logic             timer_en;
	logic [PS_W-1:0]  ps_cnt;                         // Prescale divider
	logic [DW-1:0]    count;
	logic [DW-1:0]    count_inc;
	logic [DW-1:0]    compare;
	logic             expired;
	logic             tick;                           // Count step this cycle
	logic             wr_en;
	logic [1:0]       ofs;

	assign ofs       = req.addr[1:0];
	assign tick      = timer_en && (ps_cnt == PS_LAST);
	assign count_inc = count + 1'b1;
	assign irq_out   = expired;                       // Straight from a flop

	always_ff @(posedge clk_in)
	begin
		if (reset_in)
		begin
			state    <= WAIT_REQ;
			timer_en <= 1'b0;
			ps_cnt   <= '0;
			count    <= '0;
			compare  <= '0;
			expired  <= 1'b0;
		end
		else
		begin
			state <= next_state;
			if (timer_en)
				ps_cnt <= tick ? '0 : ps_cnt + 1'b1;
			if (wr_en && ofs == OFS_CTRL)
				timer_en <= req.wr_data[0];
			if (wr_en && ofs == OFS_COMPARE)
				compare <= req.wr_data;
			if (wr_en && ofs == OFS_COUNT)
				count <= req.wr_data;                 // Load beats the step
			else if (tick)
				count <= count_inc;
			// Set only on the step that reaches COMPARE so a clear sticks
			if (wr_en && ofs == OFS_STATUS && req.wr_data[0])
				expired <= 1'b0;
			else if (tick && compare != '0 && count_inc == compare)
				expired <= 1'b1;
		end
	end

	always_comb
	begin
		ack        = '0;
		wr_en      = 1'b0;
		next_state = state;
		case (state)
			WAIT_REQ:
			begin
				if (req.req)
					next_state = (req.op == eio_pkg::EIO_WRITE) ? WR_ACK : RD_ACK;
			end
			RD_ACK:
			begin
				ack.ack    = 1'b1;
				next_state = WAIT_REQ;
				case (ofs)
					OFS_CTRL:    ack.ack_data = DW'(timer_en);
					OFS_COUNT:   ack.ack_data = count;
					OFS_COMPARE: ack.ack_data = compare;
					default:     ack.ack_data = DW'(expired);
				endcase
			end
			WR_ACK:
			begin
				ack.ack    = 1'b1;
				wr_en      = 1'b1;
				next_state = WAIT_REQ;
			end
			default: next_state = WAIT_REQ;
		endcase
	end

endmodule

// ==== logic/io_subsystem.sv ====
/*
 * External I/O subsystem top: decoder, scratch register,
 * interval timer and GPIO port
 */

`timescale 1ns/1ps

module io_subsystem #(
	parameter logic [eio_pkg::EIO_ADDR_W-1:0] REG_BASE   = 16'h0100,
	parameter logic [eio_pkg::EIO_ADDR_W-1:0] TIMER_BASE = 16'h0200,
	parameter logic [eio_pkg::EIO_ADDR_W-1:0] GPIO_BASE  = 16'h0300,
	parameter int                             PRESCALE   = 4
) (
	input  logic              clk_in,                 // Clock
	input  logic              reset_in,               // Sync reset, active high
	input  eio_pkg::eio_req_t bus_req,                // From CPU-side master
	output eio_pkg::eio_ack_t bus_ack,                // To CPU-side master
	input  logic [7:0]        gpio_in,
	output logic [7:0]        gpio_out,
	output logic              irq_out                 // Timer interrupt
);

	eio_pkg::eio_req_t slave_req [eio_pkg::EIO_SLAVE_COUNT];
	eio_pkg::eio_ack_t slave_ack [eio_pkg::EIO_SLAVE_COUNT];

	io_bus_decoder #(
		.REG_BASE   (REG_BASE),
		.TIMER_BASE (TIMER_BASE),
		.GPIO_BASE  (GPIO_BASE)
	) u_decoder (
		.clk_in    (clk_in),
		.reset_in  (reset_in),
		.bus_req   (bus_req),
		.bus_ack   (bus_ack),
		.slave_req (slave_req),
		.slave_ack (slave_ack)
	);

	external_register u_ext_reg (                     // Slot 0
		.clk_in   (clk_in),
		.reset_in (reset_in),
		.req      (slave_req[0]),
		.ack      (slave_ack[0])
	);

	io_interval_timer #(
		.PRESCALE (PRESCALE)
	) u_timer (                                       // Slot 1
		.clk_in   (clk_in),
		.reset_in (reset_in),
		.req      (slave_req[1]),
		.ack      (slave_ack[1]),
		.irq_out  (irq_out)
	);

	io_gpio_port u_gpio (                             // Slot 2
		.clk_in   (clk_in),
		.reset_in (reset_in),
		.req      (slave_req[2]),
		.ack      (slave_ack[2]),
		.gpio_in  (gpio_in),
		.gpio_out (gpio_out)
	);

endmodule
